//--- include/ibuf_config.svh
// Instruction buffer sizes
`ifndef IBUF_CONFIG_SVH
`define IBUF_CONFIG_SVH

// Packets offered by fetch each cycle, two per fetch slot
`define IB_WRITE_LANES 4

// Packets offered to dispatch at once
`define IB_DISPATCH_WIDTH 4
`define IB_DISPATCH_LOG 2

// Queue slots, kept a power of two so pointers wrap on their own
`define IB_DEPTH 16
`define IB_DEPTH_LOG 4

`endif

//--- design/ibufPkg.sv
// Instruction buffer types
`include "ibuf_config.svh"

package ibufPkg;

	// One instruction as it travels from fetch to dispatch
	typedef struct packed {
		logic valid;
		logic isCsr;
		logic exception;
		logic [31:0] instWord;
	} instPkt_t;

	// Slot index into the circular queue
	typedef logic [`IB_DEPTH_LOG-1:0] ibufPtr_t;

	// Occupancy, one bit wider to hold a full queue
	typedef logic [`IB_DEPTH_LOG:0] ibufCount_t;

	// Packets leaving in one transfer
	typedef logic [`IB_DISPATCH_LOG:0] dispCount_t;
	typedef logic [`IB_DISPATCH_WIDTH-1:0] dispMask_t;

endpackage

//--- design/ibufRam.sv
// Instruction buffer storage
`timescale 1ns/1ps
`include "ibuf_config.svh"

module ibufRam (
	input  logic                      clk,
	input  logic [`IB_WRITE_LANES-1:0] wrEn_i,
	input  ibufPkg::ibufPtr_t          wrAddr_i [0:`IB_WRITE_LANES-1],
	input  ibufPkg::instPkt_t          wrData_i [0:`IB_WRITE_LANES-1],
	input  ibufPkg::ibufPtr_t          rdAddr_i [0:`IB_DISPATCH_WIDTH-1],
	output ibufPkg::instPkt_t          rdData_o [0:`IB_DISPATCH_WIDTH-1]
);

	// Packet array
	ibufPkg::instPkt_t mem [0:`IB_DEPTH-1];

	// All write ports land at the same edge
	// Addresses are compacted upstream so they never collide
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `IB_WRITE_LANES; i++)
		begin
			if (wrEn_i[i])
			begin
				mem[wrAddr_i[i]] <= wrData_i[i];
			end
		end
	end

	// Read ports are plain muxes off the head-relative addresses
	always_comb
	begin
		for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
		begin
			rdData_o[i] = mem[rdAddr_i[i]];
		end
	end

endmodule

//--- design/ibufPointers.sv
// Instruction buffer pointers
`timescale 1ns/1ps
`include "ibuf_config.svh"

module ibufPointers (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       flush_i,
	input  logic                       inValid_i,
	input  logic [`IB_WRITE_LANES-1:0] laneValid_i,
	input  logic                       dispFire_i,
	input  ibufPkg::dispCount_t        dispCount_i,
	output logic                       inReady_o,
	output logic [`IB_WRITE_LANES-1:0] wrEn_o,
	output ibufPkg::ibufPtr_t          wrAddr_o [0:`IB_WRITE_LANES-1],
	output ibufPkg::ibufPtr_t          rdAddr_o [0:`IB_DISPATCH_WIDTH-1],
	output ibufPkg::ibufCount_t        count_o
);

	// Oldest entry
	ibufPkg::ibufPtr_t head;
	// Next free slot
	ibufPkg::ibufPtr_t tail;
	// Entries held
	ibufPkg::ibufCount_t count;

	// Lanes written and leaving this cycle
	ibufPkg::ibufCount_t numWritten;
	ibufPkg::ibufCount_t numRead;

	// Room for a whole bundle, decided from the count alone
	assign inReady_o = (count <= ibufPkg::ibufCount_t'(`IB_DEPTH - `IB_WRITE_LANES));

	// Compaction: every valid lane takes the next slot after the tail
	// Invalid lanes consume no slot
	always_comb
	begin
		ibufPkg::ibufPtr_t offset;
		offset = '0;
		numWritten = '0;
		for (int i = 0; i < `IB_WRITE_LANES; i++)
		begin
			wrEn_o[i] = inValid_i & inReady_o & laneValid_i[i];
			wrAddr_o[i] = tail + offset;
			if (laneValid_i[i])
			begin
				offset = offset + 1'b1;
			end
			numWritten = numWritten + ibufPkg::ibufCount_t'(wrEn_o[i]);
		end
	end

	// Read lanes walk forward from the head, wrap is free at power-of-two depth
	always_comb
	begin
		for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
		begin
			rdAddr_o[i] = head + ibufPkg::ibufPtr_t'(i);
		end
	end

	// Only a fired transfer drains entries
	assign numRead = dispFire_i ? ibufPkg::ibufCount_t'(dispCount_i) : '0;

	// Head, tail and count move together
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			// Flush drops everything, including a bundle arriving now
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= head + ibufPkg::ibufPtr_t'(numRead);
			tail <= tail + ibufPkg::ibufPtr_t'(numWritten);
			// Writes and reads in the same cycle net out
			count <= count + numWritten - numRead;
		end
	end

	assign count_o = count;

endmodule

//--- design/dispatchGate.sv
// Dispatch lane gating
`timescale 1ns/1ps
`include "ibuf_config.svh"

module dispatchGate (
	input  logic                clk,
	input  logic                reset,
	input  logic                flush_i,
	input  logic                commitCsr_i,
	input  logic                outReady_i,
	input  ibufPkg::ibufCount_t count_i,
	input  ibufPkg::instPkt_t   rawPacket_i [0:`IB_DISPATCH_WIDTH-1],
	output logic                outValid_o,
	output ibufPkg::instPkt_t   outPacket_o [0:`IB_DISPATCH_WIDTH-1],
	output logic                dispFire_o,
	output ibufPkg::dispCount_t dispCount_o
);

	// Waiting for an older CSR to commit
	logic csrWait;
	// Waiting for the flush that follows an exception
	logic excWait;

	// Lanes allowed through this cycle
	ibufPkg::dispMask_t laneMask;

	// Serializing lanes in the offered bundle
	logic csrSeen;
	logic excSeen;

	// Offer only a full dispatch width, and never while serialized
	assign outValid_o = (count_i >= ibufPkg::ibufCount_t'(`IB_DISPATCH_WIDTH))
		& ~csrWait & ~excWait;

	assign dispFire_o = outValid_o & outReady_i;

	// Lane 0 always goes
	// A CSR or exception lane goes too, but everything after it is cut
	always_comb
	begin
		laneMask = '0;
		laneMask[0] = 1'b1;
		for (int i = 1; i < `IB_DISPATCH_WIDTH; i++)
		begin
			laneMask[i] = laneMask[i-1]
				& ~(rawPacket_i[i-1].isCsr | rawPacket_i[i-1].exception);
		end
	end

	// Masked lanes and idle cycles show an all-zero packet
	always_comb
	begin
		for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
		begin
			if (outValid_o & laneMask[i])
				outPacket_o[i] = rawPacket_i[i];
			else
				outPacket_o[i] = '0;
		end
	end

	// Count surviving lanes and spot serializing ones
	always_comb
	begin
		dispCount_o = '0;
		csrSeen = 1'b0;
		excSeen = 1'b0;
		for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
		begin
			dispCount_o = dispCount_o + ibufPkg::dispCount_t'(outPacket_o[i].valid);
			csrSeen = csrSeen | (outPacket_o[i].valid & outPacket_o[i].isCsr);
			excSeen = excSeen | (outPacket_o[i].valid & outPacket_o[i].exception);
		end
	end

	// Flags set on the firing edge, flush wins over everything
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			csrWait <= 1'b0;
			excWait <= 1'b0;
		end
		else if (flush_i)
		begin
			csrWait <= 1'b0;
			excWait <= 1'b0;
		end
		else
		begin
			if (commitCsr_i)
				csrWait <= 1'b0;
			else if (dispFire_o & csrSeen)
				csrWait <= 1'b1;
			// Only a flush releases an exception
			if (dispFire_o & excSeen)
				excWait <= 1'b1;
		end
	end

endmodule

//--- design/instBuffer.sv
// Instruction buffer top
`timescale 1ns/1ps
`include "ibuf_config.svh"

module instBuffer (
	input  logic              clk,
	input  logic              reset,
	input  logic              flushIn_i,
	input  logic              commitCsr_i,
	input  logic              inValid_i,
	input  ibufPkg::instPkt_t inPacket_i [0:`IB_WRITE_LANES-1],
	output logic              inReady_o,
	input  logic              outReady_i,
	output logic              outValid_o,
	output ibufPkg::instPkt_t outPacket_o [0:`IB_DISPATCH_WIDTH-1]
);

	// Write side
	logic [`IB_WRITE_LANES-1:0] laneValid;
	logic [`IB_WRITE_LANES-1:0] wrEn;
	ibufPkg::ibufPtr_t wrAddr [0:`IB_WRITE_LANES-1];

	// Read side
	ibufPkg::ibufPtr_t rdAddr [0:`IB_DISPATCH_WIDTH-1];
	ibufPkg::instPkt_t rawPacket [0:`IB_DISPATCH_WIDTH-1];
	ibufPkg::ibufCount_t count;
	logic dispFire;
	ibufPkg::dispCount_t dispCount;

	// Per-lane valid bits pulled out of the bundle
	always_comb
	begin
		for (int i = 0; i < `IB_WRITE_LANES; i++)
		begin
			laneValid[i] = inPacket_i[i].valid;
		end
	end

	ibufPointers i_ibufPointers (
		.clk         (clk),
		.reset       (reset),
		.flush_i     (flushIn_i),
		.inValid_i   (inValid_i),
		.laneValid_i (laneValid),
		.dispFire_i  (dispFire),
		.dispCount_i (dispCount),
		.inReady_o   (inReady_o),
		.wrEn_o      (wrEn),
		.wrAddr_o    (wrAddr),
		.rdAddr_o    (rdAddr),
		.count_o     (count)
	);

	ibufRam i_ibufRam (
		.clk      (clk),
		.wrEn_i   (wrEn),
		.wrAddr_i (wrAddr),
		.wrData_i (inPacket_i),
		.rdAddr_i (rdAddr),
		.rdData_o (rawPacket)
	);

	dispatchGate i_dispatchGate (
		.clk         (clk),
		.reset       (reset),
		.flush_i     (flushIn_i),
		.commitCsr_i (commitCsr_i),
		.outReady_i  (outReady_i),
		.count_i     (count),
		.rawPacket_i (rawPacket),
		.outValid_o  (outValid_o),
		.outPacket_o (outPacket_o),
		.dispFire_o  (dispFire),
		.dispCount_o (dispCount)
	);

endmodule

//--- bench/instBuffer_chk.sv
// Instruction buffer checker
`timescale 1ns/1ps
`include "ibuf_config.svh"

module instBuffer_chk (
	input logic              clk,
	input logic              reset,
	input logic              flushIn_i,
	input logic              commitCsr_i,
	input logic              inValid_i,
	input ibufPkg::instPkt_t inPacket_i [0:`IB_WRITE_LANES-1],
	input logic              inReady_o,
	input logic              outReady_i,
	input logic              outValid_o,
	input ibufPkg::instPkt_t outPacket_o [0:`IB_DISPATCH_WIDTH-1]
);

	// Sticky, watched by the testbench
	logic errSeen = 1'b0;
	// Sequence number due on lane 0 of the current offer
	logic [31:0] nextSeq;
	// Packets accepted and not yet dispatched
	int held;
	int numIn;
	int numOut;
	// Stalls owed by transfers already seen
	logic csrPend;
	logic excPend;
	logic flushSeen;
	logic afterReset;
	logic dispCsr;
	logic dispExc;
	ibufPkg::dispMask_t gotMask;
	ibufPkg::dispMask_t expMask;
	logic [31:0] badGot;
	logic [31:0] badExp;
	logic orderOk;
	logic expReady;
	logic stallOk;
	// CSR and exception flags sent with each sequence number
	// Live sequence numbers span less than 32
	logic [1:0] sentFlags [0:31];
	logic fieldOk;
	ibufPkg::instPkt_t badPkt;
	ibufPkg::instPkt_t expPkt;

	always_comb
	begin
		logic go;
		go = outValid_o;
		numIn = 0;
		numOut = 0;
		dispCsr = 1'b0;
		dispExc = 1'b0;
		orderOk = 1'b1;
		badGot = '0;
		badExp = '0;
		fieldOk = 1'b1;
		badPkt = '0;
		expPkt = '0;
		for (int i = 0; i < `IB_WRITE_LANES; i++)
			numIn += int'(inValid_i & inReady_o & inPacket_i[i].valid);
		for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
		begin
			gotMask[i] = outPacket_o[i].valid;
			expMask[i] = go;
			// A CSR or exception lane closes the bundle
			go = go & outPacket_o[i].valid & ~outPacket_o[i].isCsr & ~outPacket_o[i].exception;
			if (outValid_o & outReady_i & outPacket_o[i].valid)
			begin
				numOut++;
				dispCsr |= outPacket_o[i].isCsr;
				dispExc |= outPacket_o[i].exception;
			end
			if (orderOk & outPacket_o[i].valid & (outPacket_o[i].instWord != nextSeq + 32'(i)))
			begin
				orderOk = 1'b0;
				badGot = outPacket_o[i].instWord;
				badExp = nextSeq + 32'(i);
			end
			// Dropped lanes are all zero, kept lanes carry the flags they were sent with
			if (fieldOk & ~outPacket_o[i].valid & (outPacket_o[i] != '0))
			begin
				fieldOk = 1'b0;
				badPkt = outPacket_o[i];
				expPkt = '0;
			end
			else if (fieldOk & outPacket_o[i].valid
				& ({outPacket_o[i].isCsr, outPacket_o[i].exception}
				!= sentFlags[outPacket_o[i].instWord[4:0]]))
			begin
				fieldOk = 1'b0;
				badPkt = outPacket_o[i];
				expPkt = outPacket_o[i];
				expPkt.isCsr = sentFlags[outPacket_o[i].instWord[4:0]][1];
				expPkt.exception = sentFlags[outPacket_o[i].instWord[4:0]][0];
			end
		end
	end

	// Room for a whole bundle
	assign expReady = (held <= `IB_DEPTH - `IB_WRITE_LANES);
	assign stallOk = ~(outValid_o & (csrPend | excPend | flushSeen));

	// Flags of every accepted lane, by sequence number
	always @(posedge clk)
	begin
		for (int i = 0; i < `IB_WRITE_LANES; i++)
			if (inValid_i & inReady_o & inPacket_i[i].valid)
				sentFlags[inPacket_i[i].instWord[4:0]] <=
					{inPacket_i[i].isCsr, inPacket_i[i].exception};
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			afterReset <= 1'b1;
			flushSeen <= 1'b0;
		end
		else
		begin
			afterReset <= 1'b0;
			flushSeen <= flushIn_i;
		end
		// Numbering restarts with an empty queue
		if (reset | flushIn_i)
		begin
			nextSeq <= '0;
			held <= 0;
			csrPend <= 1'b0;
			excPend <= 1'b0;
		end
		else
		begin
			held <= held + numIn - numOut;
			nextSeq <= nextSeq + 32'(numOut);
			csrPend <= ~commitCsr_i & (csrPend | dispCsr);
			excPend <= excPend | dispExc;
		end
	end

	always @(posedge clk)
	begin
		if (((reset | afterReset) & (outValid_o | ~inReady_o))
			| (~reset & ~(orderOk & stallOk & fieldOk & (gotMask == expMask)
			& (inReady_o == expReady))))
			errSeen <= 1'b1;
	end

	// Quiet outputs in reset and at the first edge after it
	assert property (@(posedge clk) (reset | afterReset) |-> (~outValid_o & inReady_o))
		else $error("FAIL outValid_o %h inReady_o %h around reset",
			$sampled(outValid_o), $sampled(inReady_o));
	// In order, no gaps
	assert property (@(posedge clk) disable iff (reset) orderOk)
		else $error("FAIL outPacket_o.instWord %h expected %h", $sampled(badGot), $sampled(badExp));
	// Lane 0 leads, nothing after a serializing lane
	assert property (@(posedge clk) disable iff (reset) gotMask == expMask)
		else $error("FAIL outPacket_o.valid lanes %h expected %h",
			$sampled(gotMask), $sampled(expMask));
	// Payload fields as sent
	assert property (@(posedge clk) disable iff (reset) fieldOk)
		else $error("FAIL outPacket_o %h expected %h", $sampled(badPkt), $sampled(expPkt));
	assert property (@(posedge clk) disable iff (reset) inReady_o == expReady)
		else $error("FAIL inReady_o %h expected %h", $sampled(inReady_o), $sampled(expReady));
	// Nothing offered while a CSR or exception waits, nor after a flush
	assert property (@(posedge clk) disable iff (reset) stallOk)
		else $error("FAIL outValid_o %h expected 0 during a stall", $sampled(outValid_o));

endmodule

bind instBuffer instBuffer_chk i_instBuffer_chk (.*);

//--- bench/instBufferTb.sv
// Instruction buffer testbench
`timescale 1ns/1ps
`include "ibuf_config.svh"

module instBufferTb;

	localparam int ClkPeriod = 100;
	localparam int ResetCycles = 4;
	localparam int RunCycles = 3000;
	localparam int MarginCycles = 200;

	logic clk;
	logic reset;
	logic flushIn;
	logic commitCsr;
	logic inValid;
	logic inReady;
	logic outReady;
	logic outValid;
	ibufPkg::instPkt_t inPacket [0:`IB_WRITE_LANES-1];
	ibufPkg::instPkt_t outPacket [0:`IB_DISPATCH_WIDTH-1];

	// Number of the first valid lane on the inputs, and how many lanes follow
	int seqBase = 0;
	int bundleCount = 0;
	// Cycles to the next commit or flush, zero when idle
	int csrDelay = 0;
	int excDelay = 0;
	int cycle = 0;

	instBuffer i_instBuffer (
		.clk         (clk),
		.reset       (reset),
		.flushIn_i   (flushIn),
		.commitCsr_i (commitCsr),
		.inValid_i   (inValid),
		.inPacket_i  (inPacket),
		.inReady_o   (inReady),
		.outReady_i  (outReady),
		.outValid_o  (outValid),
		.outPacket_o (outPacket)
	);

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	// Fresh bundle numbered from base, invalid lanes carry junk
	task automatic driveBundle(input int base);
		ibufPkg::instPkt_t pkt;
		bundleCount = 0;
		for (int i = 0; i < `IB_WRITE_LANES; i++)
		begin
			pkt.valid = ($urandom % 4) != 0;
			pkt.isCsr = ($urandom % 40) == 0;
			pkt.exception = ($urandom % 70) == 0;
			pkt.instWord = pkt.valid ? 32'(base + bundleCount) : $urandom;
			bundleCount += int'(pkt.valid);
			inPacket[i] <= pkt;
		end
		seqBase = base;
	endtask

	// Random stimulus, one step per rising edge
	initial
	begin
		logic csrOut;
		logic excOut;
		void'($urandom(86584));
		forever
		begin
			@(posedge clk);
			csrOut = 1'b0;
			excOut = 1'b0;
			// Serializing lanes leaving at this edge
			for (int i = 0; i < `IB_DISPATCH_WIDTH; i++)
			begin
				csrOut |= outValid & outReady & outPacket[i].valid & outPacket[i].isCsr;
				excOut |= outValid & outReady & outPacket[i].valid & outPacket[i].exception;
			end
			if (!reset)
			begin
				cycle++;
				// Flush empties the queue
				if (flushIn)
					driveBundle(0);
				else if (inValid & inReady)
					driveBundle(seqBase + bundleCount);
				else
					driveBundle(seqBase);
				if (csrOut)
					csrDelay = 2 + $urandom % 6;
				if (excOut)
					excDelay = 1 + $urandom % 4;
				commitCsr <= (csrDelay == 1);
				flushIn <= (excDelay == 1) || (($urandom % 150) == 0);
				if (csrDelay > 0)
					csrDelay--;
				if (excDelay > 0)
					excDelay--;
				inValid <= ($urandom % 4) != 0;
				// Light and heavy back-pressure phases, heavy ones fill the queue
				outReady <= ((cycle / 200) % 2 == 0) ? ($urandom % 4 != 0) : ($urandom % 4 == 0);
			end
		end
	end

	// First failed check ends the run
	always @(posedge clk)
	begin
		if (i_instBuffer.i_instBuffer_chk.errSeen)
		begin
			$display("Test FAILED");
			$fatal(1, "Bound checker reported an assertion failure");
		end
	end

	initial
	begin
		#(ClkPeriod * (ResetCycles + RunCycles + MarginCycles));
		$display("Watchdog expired before the test sequence finished");
		$display("Test FAILED");
		$fatal(1, "Timeout");
	end

	initial
	begin
		reset = 1'b1;
		flushIn = 1'b0;
		commitCsr = 1'b0;
		inValid = 1'b0;
		outReady = 1'b0;
		for (int i = 0; i < `IB_WRITE_LANES; i++)
			inPacket[i] = '0;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
		repeat (RunCycles) @(posedge clk);
		if (i_instBuffer.i_instBuffer_chk.errSeen)
		begin
			$display("Test FAILED");
			$fatal(1, "Bound checker reported an assertion failure");
		end
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- vlog.f
+incdir+include
design/ibufPkg.sv
design/ibufRam.sv
design/ibufPointers.sv
design/dispatchGate.sv
design/instBuffer.sv
bench/instBuffer_chk.sv
bench/instBufferTb.sv

//--- run.sh
#!/bin/bash
# Build and run the instruction buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module instBufferTb -f vlog.f -o simInstBuffer \
	&& ./obj_dir/simInstBuffer +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
